// File: include/mips_ex_defs.svh
`ifndef MIPS_EX_DEFS_SVH
`define MIPS_EX_DEFS_SVH

//////////////////////////////////////////////////////////////////////////////
// execute stage widths
//////////////////////////////////////////////////////////////////////////////

// general register and data word width
`define MIPS_EX_XLEN 32

// register file address width
`define MIPS_EX_REG_AW 5

// shift amount taken from the low bits of operand a
`define MIPS_EX_SHAMT_W 5

`endif

// File: hdl/mips_ex_pkg.sv
`default_nettype none

`include "mips_ex_defs.svh"

package mips_ex_pkg;

    // execute stage operations
    typedef enum logic [4:0] {
        OP_ADD,
        OP_ADDU,
        OP_SUB,
        OP_SUBU,
        OP_SLT,
        OP_SLTU,
        OP_AND,
        OP_OR,
        OP_XOR,
        OP_NOR,
        OP_SLL,
        OP_SRL,
        OP_SRA,
        OP_MULT,
        OP_MULTU,
        OP_MUL,
        OP_MFHI,
        OP_MFLO,
        OP_MTHI,
        OP_MTLO
    } ex_op_e;

    // one issued instruction
    typedef struct packed {
        logic                        valid;
        ex_op_e                      op;
        logic [`MIPS_EX_XLEN-1:0]    a;
        logic [`MIPS_EX_XLEN-1:0]    b;
        logic [`MIPS_EX_REG_AW-1:0]  waddr;
        logic                        wen;
    } ex_issue_t;

    // registered result towards write-back
    typedef struct packed {
        logic                        valid;
        logic                        wen;
        logic [`MIPS_EX_REG_AW-1:0]  waddr;
        logic [`MIPS_EX_XLEN-1:0]    wdata;
        logic                        ovf;
    } ex_wb_t;

    // hi/lo pair contents
    typedef struct packed {
        logic [`MIPS_EX_XLEN-1:0]    hi;
        logic [`MIPS_EX_XLEN-1:0]    lo;
    } ex_hilo_t;

endpackage

`default_nettype wire

// File: hdl/ex_alu.sv
`timescale 1ns/1ps
`default_nettype none

`include "mips_ex_defs.svh"

module ex_alu (
    input  mips_ex_pkg::ex_op_e       op_i,
    input  wire [`MIPS_EX_XLEN-1:0]   a_i,
    input  wire [`MIPS_EX_XLEN-1:0]   b_i,
    output logic [`MIPS_EX_XLEN-1:0]  result_o,
    output logic                      ovf_o
);

    ////////////////////////////////////////////////////////////////////////////
    // shared adder
    ////////////////////////////////////////////////////////////////////////////

    logic                        sub_sel;
    logic [`MIPS_EX_XLEN-1:0]    b_opnd;
    logic [`MIPS_EX_XLEN:0]      sum_ext;
    logic [`MIPS_EX_XLEN-1:0]    sum;
    logic                        carry;
    logic                        ovf_raw;
    logic                        lt_signed;
    logic                        lt_unsigned;
    logic [`MIPS_EX_SHAMT_W-1:0] shamt;

    // subtracts and both compares go through a + ~b + 1
    assign sub_sel = (op_i == mips_ex_pkg::OP_SUB)  ||
                     (op_i == mips_ex_pkg::OP_SUBU) ||
                     (op_i == mips_ex_pkg::OP_SLT)  ||
                     (op_i == mips_ex_pkg::OP_SLTU);

    assign b_opnd  = sub_sel ? ~b_i : b_i;
    assign sum_ext = {1'b0, a_i} + {1'b0, b_opnd} + {{`MIPS_EX_XLEN{1'b0}}, sub_sel};
    assign sum     = sum_ext[`MIPS_EX_XLEN-1:0];
    assign carry   = sum_ext[`MIPS_EX_XLEN];

    // operands agree in sign but the sum does not
    assign ovf_raw = (a_i[`MIPS_EX_XLEN-1] == b_opnd[`MIPS_EX_XLEN-1]) &&
                     (sum[`MIPS_EX_XLEN-1] != a_i[`MIPS_EX_XLEN-1]);

    // signed: sign of the true difference; unsigned: borrow out
    assign lt_signed   = sum[`MIPS_EX_XLEN-1] ^ ovf_raw;
    assign lt_unsigned = ~carry;

    // only the trapping forms raise the flag
    assign ovf_o = ovf_raw && ((op_i == mips_ex_pkg::OP_ADD) ||
                               (op_i == mips_ex_pkg::OP_SUB));

    assign shamt = a_i[`MIPS_EX_SHAMT_W-1:0];

    ////////////////////////////////////////////////////////////////////////////
    // result select
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        case (op_i)
            mips_ex_pkg::OP_ADD,
            mips_ex_pkg::OP_ADDU,
            mips_ex_pkg::OP_SUB,
            mips_ex_pkg::OP_SUBU: begin
                result_o = sum;
            end
            mips_ex_pkg::OP_SLT: begin
                result_o = {{(`MIPS_EX_XLEN-1){1'b0}}, lt_signed};
            end
            mips_ex_pkg::OP_SLTU: begin
                result_o = {{(`MIPS_EX_XLEN-1){1'b0}}, lt_unsigned};
            end
            mips_ex_pkg::OP_AND: begin
                result_o = a_i & b_i;
            end
            mips_ex_pkg::OP_OR: begin
                result_o = a_i | b_i;
            end
            mips_ex_pkg::OP_XOR: begin
                result_o = a_i ^ b_i;
            end
            mips_ex_pkg::OP_NOR: begin
                result_o = ~(a_i | b_i);
            end
            mips_ex_pkg::OP_SLL: begin
                result_o = b_i << shamt;
            end
            mips_ex_pkg::OP_SRL: begin
                result_o = b_i >> shamt;
            end
            mips_ex_pkg::OP_SRA: begin
                result_o = $signed(b_i) >>> shamt;
            end
            // multiply and hi/lo moves are sourced elsewhere
            default: begin
                result_o = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: hdl/ex_mul.sv
`timescale 1ns/1ps
`default_nettype none

`include "mips_ex_defs.svh"

module ex_mul (
    input  mips_ex_pkg::ex_op_e          op_i,
    input  wire [`MIPS_EX_XLEN-1:0]      a_i,
    input  wire [`MIPS_EX_XLEN-1:0]      b_i,
    output logic [2*`MIPS_EX_XLEN-1:0]   product_o
);

    logic                          signed_mode;
    logic                          negate;
    logic [`MIPS_EX_XLEN-1:0]      mag_a;
    logic [`MIPS_EX_XLEN-1:0]      mag_b;
    logic [2*`MIPS_EX_XLEN-1:0]    prod_mag;

    // mult and mul treat operands as two's complement
    assign signed_mode = (op_i == mips_ex_pkg::OP_MULT) ||
                         (op_i == mips_ex_pkg::OP_MUL);

    // magnitudes; -2^31 maps onto itself, which is right as unsigned
    assign mag_a = (signed_mode && a_i[`MIPS_EX_XLEN-1]) ? (~a_i + 1'b1) : a_i;
    assign mag_b = (signed_mode && b_i[`MIPS_EX_XLEN-1]) ? (~b_i + 1'b1) : b_i;

    assign prod_mag = {{`MIPS_EX_XLEN{1'b0}}, mag_a} * {{`MIPS_EX_XLEN{1'b0}}, mag_b};

    // sign of the product
    assign negate = signed_mode && (a_i[`MIPS_EX_XLEN-1] ^ b_i[`MIPS_EX_XLEN-1]);

    assign product_o = negate ? (~prod_mag + 1'b1) : prod_mag;

endmodule

`default_nettype wire

// File: hdl/ex_hilo_regs.sv
`timescale 1ns/1ps
`default_nettype none

`include "mips_ex_defs.svh"

module ex_hilo_regs (
    input  wire                          clk,
    input  wire                          rst_i,
    input  mips_ex_pkg::ex_issue_t       issue_i,
    input  wire [2*`MIPS_EX_XLEN-1:0]    product_i,
    output mips_ex_pkg::ex_hilo_t        hilo_o
);

    mips_ex_pkg::ex_hilo_t hilo_q;
    mips_ex_pkg::ex_hilo_t hilo_d;
    logic                  hilo_we;

    // next value of the pair
    always_comb begin
        hilo_d  = hilo_q;
        hilo_we = 1'b0;
        if (issue_i.valid) begin
            case (issue_i.op)
                mips_ex_pkg::OP_MULT,
                mips_ex_pkg::OP_MULTU: begin
                    hilo_we   = 1'b1;
                    hilo_d.hi = product_i[2*`MIPS_EX_XLEN-1:`MIPS_EX_XLEN];
                    hilo_d.lo = product_i[`MIPS_EX_XLEN-1:0];
                end
                mips_ex_pkg::OP_MTHI: begin
                    hilo_we   = 1'b1;
                    hilo_d.hi = issue_i.a;
                end
                mips_ex_pkg::OP_MTLO: begin
                    hilo_we   = 1'b1;
                    hilo_d.lo = issue_i.a;
                end
                default: begin
                    hilo_we = 1'b0;
                end
            endcase
        end
    end

    // architectural state, cleared to zero
    always_ff @(posedge clk) begin
        if (rst_i) begin
            hilo_q <= '0;
        end else if (hilo_we) begin
            hilo_q <= hilo_d;
        end
    end

    // current pair for mfhi / mflo
    assign hilo_o = hilo_q;

endmodule

`default_nettype wire

// File: hdl/ex_writeback.sv
`timescale 1ns/1ps
`default_nettype none

`include "mips_ex_defs.svh"

module ex_writeback (
    input  wire                          clk,
    input  wire                          rst_i,
    input  mips_ex_pkg::ex_issue_t       issue_i,
    input  wire [`MIPS_EX_XLEN-1:0]      alu_result_i,
    input  wire                          alu_ovf_i,
    input  wire [`MIPS_EX_XLEN-1:0]      mul_lo_i,
    input  mips_ex_pkg::ex_hilo_t        hilo_i,
    output mips_ex_pkg::ex_wb_t          wb_o
);

    logic [`MIPS_EX_XLEN-1:0]  wdata_d;
    logic                      ovf_d;
    logic                      wen_d;
    mips_ex_pkg::ex_wb_t       wb_q;

    ////////////////////////////////////////////////////////////////////////////
    // result source from the opcode
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        case (issue_i.op)
            mips_ex_pkg::OP_MUL: begin
                wdata_d = mul_lo_i;
            end
            mips_ex_pkg::OP_MFHI: begin
                wdata_d = hilo_i.hi;
            end
            mips_ex_pkg::OP_MFLO: begin
                wdata_d = hilo_i.lo;
            end
            // these only touch hi/lo
            mips_ex_pkg::OP_MULT,
            mips_ex_pkg::OP_MULTU,
            mips_ex_pkg::OP_MTHI,
            mips_ex_pkg::OP_MTLO: begin
                wdata_d = '0;
            end
            default: begin
                wdata_d = alu_result_i;
            end
        endcase
    end

    // overflow kills the register write
    assign ovf_d = issue_i.valid && alu_ovf_i;
    assign wen_d = issue_i.valid && issue_i.wen && !alu_ovf_i;

    ////////////////////////////////////////////////////////////////////////////
    // output register
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst_i) begin
            wb_q.valid <= 1'b0;
            wb_q.wen   <= 1'b0;
            wb_q.ovf   <= 1'b0;
        end else begin
            wb_q.valid <= issue_i.valid;
            wb_q.wen   <= wen_d;
            wb_q.ovf   <= ovf_d;
        end
    end

    // payload
    always_ff @(posedge clk) begin
        wb_q.waddr <= issue_i.waddr;
        wb_q.wdata <= wdata_d;
    end

    assign wb_o = wb_q;

endmodule

`default_nettype wire

// File: hdl/mips_ex_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "mips_ex_defs.svh"

module mips_ex_top (
    input  wire                      clk,
    input  wire                      rst_i,
    input  mips_ex_pkg::ex_issue_t   issue_i,
    output mips_ex_pkg::ex_wb_t      wb_o
);

    logic [`MIPS_EX_XLEN-1:0]    alu_result;
    logic                        alu_ovf;
    logic [2*`MIPS_EX_XLEN-1:0]  product;
    mips_ex_pkg::ex_hilo_t       hilo;

    // add/sub, compare, logic, shift
    ex_alu u_alu (
        .op_i     (issue_i.op),
        .a_i      (issue_i.a),
        .b_i      (issue_i.b),
        .result_o (alu_result),
        .ovf_o    (alu_ovf)
    );

    // 32x32 multiplier
    ex_mul u_mul (
        .op_i      (issue_i.op),
        .a_i       (issue_i.a),
        .b_i       (issue_i.b),
        .product_o (product)
    );

    // hi/lo pair
    ex_hilo_regs u_hilo (
        .clk       (clk),
        .rst_i     (rst_i),
        .issue_i   (issue_i),
        .product_i (product),
        .hilo_o    (hilo)
    );

    // result mux and output register
    ex_writeback u_wb (
        .clk          (clk),
        .rst_i        (rst_i),
        .issue_i      (issue_i),
        .alu_result_i (alu_result),
        .alu_ovf_i    (alu_ovf),
        .mul_lo_i     (product[`MIPS_EX_XLEN-1:0]),
        .hilo_i       (hilo),
        .wb_o         (wb_o)
    );

endmodule

`default_nettype wire

// File: bench/mips_ex_asserts.sv
`timescale 1ns/1ps
`default_nettype none

module mips_ex_asserts (
    input wire                    clk,
    input wire                    rst_i,
    input mips_ex_pkg::ex_issue_t issue_i,
    input mips_ex_pkg::ex_wb_t    wb_o
);

    int unsigned fail_count = 0;

    // result valid exactly one cycle after issue
    a_valid_latency: assert property (@(posedge clk) disable iff (rst_i)
        !$past(rst_i) |-> (wb_o.valid == $past(issue_i.valid)))
    else begin
        fail_count++;
        $error("wb_o.valid does not follow issue_i.valid by one cycle");
    end

    // trapping overflow never writes the register file
    a_ovf_no_wen: assert property (@(posedge clk) disable iff (rst_i)
        wb_o.ovf |-> !wb_o.wen)
    else begin
        fail_count++;
        $error("wb_o.ovf is high together with wb_o.wen");
    end

    // output stays quiet through reset
    a_reset_quiet: assert property (@(posedge clk) rst_i |=> !wb_o.valid)
    else begin
        fail_count++;
        $error("wb_o.valid went high while reset was asserted");
    end

endmodule

bind mips_ex_top mips_ex_asserts u_asserts (
    .clk     (clk),
    .rst_i   (rst_i),
    .issue_i (issue_i),
    .wb_o    (wb_o)
);

`default_nettype wire

// File: bench/tb_mips_ex.sv
`timescale 1ns/1ps
`default_nettype none

module tb_mips_ex;

    localparam int NUM_INSTR = 2000;

    logic                   clk = 1'b0;
    logic                   rst_i;
    mips_ex_pkg::ex_issue_t issue_i;
    mips_ex_pkg::ex_wb_t    wb_o;

    integer                 seed = 13236;
    int                     err_count = 0;
    int                     wait_cnt;
    logic [31:0]            model_hi;
    logic [31:0]            model_lo;
    mips_ex_pkg::ex_wb_t    exp_q[$];

    mips_ex_top DUT (
        .clk     (clk),
        .rst_i   (rst_i),
        .issue_i (issue_i),
        .wb_o    (wb_o)
    );

    always #2 clk = ~clk;

    ////////////////////////////////////////////////////////////////////////////
    // reference model
    ////////////////////////////////////////////////////////////////////////////

    function automatic mips_ex_pkg::ex_wb_t model_step(input mips_ex_pkg::ex_issue_t instr);
        mips_ex_pkg::ex_wb_t expd;
        longint              sa;
        longint              sb;
        longint              wide;
        logic [63:0]         uprod;
        sa   = longint'($signed(instr.a));
        sb   = longint'($signed(instr.b));
        expd = '0;
        expd.valid = instr.valid;
        if (!instr.valid) begin
            return expd;
        end
        expd.waddr = instr.waddr;
        expd.wen   = instr.wen;
        case (instr.op)
            mips_ex_pkg::OP_ADD, mips_ex_pkg::OP_SUB: begin
                wide = (instr.op == mips_ex_pkg::OP_ADD) ? sa + sb : sa - sb;
                expd.wdata = wide[31:0];
                // true result does not fit in 32 signed bits
                expd.ovf = (wide != longint'($signed(wide[31:0])));
            end
            mips_ex_pkg::OP_ADDU: expd.wdata = instr.a + instr.b;
            mips_ex_pkg::OP_SUBU: expd.wdata = instr.a - instr.b;
            mips_ex_pkg::OP_SLT:  expd.wdata = ($signed(instr.a) < $signed(instr.b)) ? 1 : 0;
            mips_ex_pkg::OP_SLTU: expd.wdata = (instr.a < instr.b) ? 1 : 0;
            mips_ex_pkg::OP_AND:  expd.wdata = instr.a & instr.b;
            mips_ex_pkg::OP_OR:   expd.wdata = instr.a | instr.b;
            mips_ex_pkg::OP_XOR:  expd.wdata = instr.a ^ instr.b;
            mips_ex_pkg::OP_NOR:  expd.wdata = ~(instr.a | instr.b);
            mips_ex_pkg::OP_SLL:  expd.wdata = instr.b << instr.a[4:0];
            mips_ex_pkg::OP_SRL:  expd.wdata = instr.b >> instr.a[4:0];
            mips_ex_pkg::OP_SRA:  expd.wdata = $signed(instr.b) >>> instr.a[4:0];
            mips_ex_pkg::OP_MULT: begin
                wide     = sa * sb;
                model_hi = wide[63:32];
                model_lo = wide[31:0];
            end
            mips_ex_pkg::OP_MULTU: begin
                uprod    = {32'd0, instr.a} * {32'd0, instr.b};
                model_hi = uprod[63:32];
                model_lo = uprod[31:0];
            end
            mips_ex_pkg::OP_MUL: begin
                wide       = sa * sb;
                expd.wdata = wide[31:0];
            end
            mips_ex_pkg::OP_MFHI: expd.wdata = model_hi;
            mips_ex_pkg::OP_MFLO: expd.wdata = model_lo;
            mips_ex_pkg::OP_MTHI: model_hi = instr.a;
            mips_ex_pkg::OP_MTLO: model_lo = instr.a;
            default: expd.wdata = '0;
        endcase
        if (expd.ovf) begin
            expd.wen = 1'b0;
        end
        return expd;
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // stimulus helpers
    ////////////////////////////////////////////////////////////////////////////

    // leans toward sign boundaries and shift amounts 0, 1 and 31
    function automatic logic [31:0] pick_operand();
        case ($unsigned($random(seed)) % 8)
            0: return 32'h7fff_ffff;
            1: return 32'h8000_0000;
            2: return 32'hffff_ffff;
            3: return 32'h0000_0000;
            4: return 32'h0000_0001;
            default: return $random(seed);
        endcase
    endfunction

    function automatic mips_ex_pkg::ex_issue_t build_instr(input mips_ex_pkg::ex_op_e op,
                                                           input logic [31:0] a,
                                                           input logic [31:0] b);
        mips_ex_pkg::ex_issue_t instr;
        instr.valid = 1'b1;
        instr.op    = op;
        instr.a     = a;
        instr.b     = b;
        instr.waddr = 5'($random(seed));
        instr.wen   = 1'b1;
        return instr;
    endfunction

    function automatic mips_ex_pkg::ex_issue_t random_instr();
        mips_ex_pkg::ex_issue_t instr;
        logic [4:0]             op_bits;
        op_bits     = 5'($unsigned($random(seed)) % 20);
        instr       = build_instr(mips_ex_pkg::ex_op_e'(op_bits), pick_operand(), pick_operand());
        // roughly one idle cycle in five
        instr.valid = ($unsigned($random(seed)) % 5) != 0;
        instr.wen   = ($unsigned($random(seed)) % 8) != 0;
        return instr;
    endfunction

    task automatic check_result(input mips_ex_pkg::ex_wb_t expd);
        assert (wb_o.valid === expd.valid && wb_o.wen === expd.wen &&
                wb_o.ovf === expd.ovf) else begin
            err_count++;
            $display("[ERROR] %0t: valid/wen/ovf %b%b%b, expected %b%b%b", $time,
                     wb_o.valid, wb_o.wen, wb_o.ovf, expd.valid, expd.wen, expd.ovf);
        end
        if (expd.valid) begin
            assert (wb_o.waddr === expd.waddr && wb_o.wdata === expd.wdata) else begin
                err_count++;
                $display("[ERROR] %0t: waddr/wdata %0d/%h, expected %0d/%h", $time,
                         wb_o.waddr, wb_o.wdata, expd.waddr, expd.wdata);
            end
        end
    endtask

    // drive one cycle, check the previous one, queue the new expectation
    task automatic issue_instr(input mips_ex_pkg::ex_issue_t instr);
        @(posedge clk);
        issue_i <= instr;
        @(negedge clk);
        if (exp_q.size() > 0) begin
            check_result(exp_q.pop_front());
        end
        exp_q.push_back(model_step(instr));
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // main sequence
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        // valid multiply held on the bus through reset
        issue_i  = build_instr(mips_ex_pkg::OP_MULT, 32'h8000_0000, 32'h7fff_ffff);
        rst_i    = 1'b1;
        model_hi = '0;
        model_lo = '0;
        wait_cnt = 0;
        while (wait_cnt < 5) begin
            @(posedge clk);
            wait_cnt++;
        end
        rst_i   <= 1'b0;
        issue_i <= '0;

        wait_cnt = 0;
        @(negedge clk);
        while (rst_i !== 1'b0 && wait_cnt < 10) begin
            @(negedge clk);
            wait_cnt++;
        end
        if (rst_i !== 1'b0) begin
            $display("Timeout: reset was never released");
            $display("Test failed");
            $finish;
        end
        assert (wb_o.valid === 1'b0) else begin
            err_count++;
            $display("[ERROR] %0t: wb_o.valid high right after reset", $time);
        end

        // hi/lo straight after reset, then overflow corners
        issue_instr(build_instr(mips_ex_pkg::OP_MFHI, 32'd0, 32'd0));
        issue_instr(build_instr(mips_ex_pkg::OP_MFLO, 32'd0, 32'd0));
        issue_instr(build_instr(mips_ex_pkg::OP_ADD, 32'h7fff_ffff, 32'd1));
        issue_instr(build_instr(mips_ex_pkg::OP_ADDU, 32'h7fff_ffff, 32'd1));
        issue_instr(build_instr(mips_ex_pkg::OP_SUB, 32'h8000_0000, 32'd1));
        issue_instr(build_instr(mips_ex_pkg::OP_SUBU, 32'h8000_0000, 32'd1));
        issue_instr(build_instr(mips_ex_pkg::OP_SRA, 32'd0, 32'h8000_0010));
        issue_instr(build_instr(mips_ex_pkg::OP_SRA, 32'd31, 32'h8000_0010));
        // mixed-sign products read back the next cycle
        issue_instr(build_instr(mips_ex_pkg::OP_MULT, 32'hffff_fffd, 32'd7));
        issue_instr(build_instr(mips_ex_pkg::OP_MFHI, 32'd0, 32'd0));
        issue_instr(build_instr(mips_ex_pkg::OP_MULTU, 32'hffff_fffd, 32'd7));
        issue_instr(build_instr(mips_ex_pkg::OP_MFLO, 32'd0, 32'd0));
        issue_instr(build_instr(mips_ex_pkg::OP_MUL, 32'h8000_0000, 32'hffff_ffff));
        issue_instr(build_instr(mips_ex_pkg::OP_MTHI, 32'h1234_5678, 32'd0));
        issue_instr(build_instr(mips_ex_pkg::OP_MFLO, 32'd0, 32'd0));
        issue_instr(build_instr(mips_ex_pkg::OP_MTLO, 32'h9abc_def0, 32'd0));
        issue_instr(build_instr(mips_ex_pkg::OP_MFHI, 32'd0, 32'd0));

        for (int i = 0; i < NUM_INSTR; i++) begin
            issue_instr(random_instr());
        end

        // drain the last result with idle cycles
        wait_cnt = 0;
        while (exp_q.size() > 0 && wait_cnt < 4) begin
            @(posedge clk);
            issue_i <= '0;
            @(negedge clk);
            check_result(exp_q.pop_front());
            wait_cnt++;
        end
        if (exp_q.size() > 0) begin
            $display("Timeout: %0d results were never checked", exp_q.size());
            $display("Test failed");
            $finish;
        end

        $display("value errors: %0d, assertion failures: %0d",
                 err_count, DUT.u_asserts.fail_count);
        if (err_count == 0 && DUT.u_asserts.fail_count == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: mips_ex.f
+incdir+include
hdl/mips_ex_pkg.sv
hdl/ex_alu.sv
hdl/ex_mul.sv
hdl/ex_hilo_regs.sv
hdl/ex_writeback.sv
hdl/mips_ex_top.sv
bench/mips_ex_asserts.sv
bench/tb_mips_ex.sv
